//--- hw/emesh_pkg.sv
package emesh_pkg;

   //##########################################################
   //# Widths
   //##########################################################
   localparam int AW = 32;                          // Address width
   localparam int DW = 32;                          // Data width
   localparam int PW = 104;                         // Full emesh packet

   //##########################################################
   //# Packet field positions
   //##########################################################
   localparam int P_WRITE_LO    = 0;                // Write flag
   localparam int P_WRITE_W     = 1;

   localparam int P_DATAMODE_LO = 1;                // Transfer size code
   localparam int P_DATAMODE_W  = 2;

   localparam int P_CTRLMODE_LO = 3;                // Control mode
   localparam int P_CTRLMODE_W  = 5;

   localparam int P_DSTADDR_LO  = 8;                // Target address
   localparam int P_DSTADDR_W   = AW;

   localparam int P_DATA_LO     = 40;               // Data word
   localparam int P_DATA_W      = DW;

   localparam int P_SRCADDR_LO  = 72;               // Return address for reads
   localparam int P_SRCADDR_W   = AW;

   //##########################################################
   //# Datamode codes
   //##########################################################
   localparam logic [1:0] DM_BYTE   = 2'd0;         // 8 bit
   localparam logic [1:0] DM_HALF   = 2'd1;         // 16 bit
   localparam logic [1:0] DM_WORD   = 2'd2;         // 32 bit
   localparam logic [1:0] DM_DOUBLE = 2'd3;         // Handled as a word here

   //##########################################################
   //# Defaults for the top level
   //##########################################################
   localparam int BANK_BIT_DEFAULT  = 10;           // Dstaddr bit picking the bank
   localparam int MEM_DEPTH_DEFAULT = 256;          // Words per bank

   // Bits 2 and up of dstaddr index a word
   localparam int WORD_LSB = 2;

endpackage

//--- hw/emesh_bank_router.sv
`timescale 1ns/1ps

module emesh_bank_router #(
   parameter int BANK_BIT = emesh_pkg::BANK_BIT_DEFAULT
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     access_in,
   input  logic [emesh_pkg::PW-1:0] packet_in,
   input  logic [1:0]               bank_wait,
   output logic                     wait_out,
   output logic [1:0]               bank_access,
   output logic [emesh_pkg::PW-1:0] bank_packet
);
   import emesh_pkg::*;

   logic          stage_valid;                      // Stage holds a packet
   logic          stage_bank;                       // Bank chosen for that packet
   logic [PW-1:0] stage_packet;                     // Payload, no reset
   logic          accept;                           // Upstream transfer this cycle
   logic          drain;                            // Stage empties into its bank
   logic          in_bank;                          // Bank select of incoming packet

   //##########################################################
   //# Steering
   //##########################################################
   assign in_bank = packet_in[P_DSTADDR_LO + BANK_BIT]; // One address bit picks the bank

   // Only the selected bank sees access
   assign bank_access[0] = stage_valid & ~stage_bank;
   assign bank_access[1] = stage_valid &  stage_bank;
   assign bank_packet    = stage_packet;            // Shared by both banks

   //##########################################################
   //# Handshake
   //##########################################################
   assign drain    = stage_valid & ~bank_wait[stage_bank];
   assign wait_out = stage_valid &  bank_wait[stage_bank]; // Full and stuck
   assign accept   = access_in & ~wait_out;         // Refill while draining

   //##########################################################
   //# Stage register
   //##########################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         stage_valid <= 1'b0;
         stage_bank  <= 1'b0;
      end else if (accept) begin
         stage_valid <= 1'b1;                       // New packet, old one gone
         stage_bank  <= in_bank;
      end else if (drain) begin
         stage_valid <= 1'b0;                       // Bank took it, nothing behind
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         stage_packet <= packet_in;
      end
   end

endmodule

//--- hw/ememory.sv
`timescale 1ns/1ps

module ememory #(
   parameter int MEM_DEPTH = emesh_pkg::MEM_DEPTH_DEFAULT
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     access_in,
   input  logic [emesh_pkg::PW-1:0] packet_in,
   input  logic                     wait_in,
   output logic                     wait_out,
   output logic                     access_out,
   output logic [emesh_pkg::PW-1:0] packet_out
);
   import emesh_pkg::*;

   localparam int IW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1; // Word index bits

   // Request fields
   logic                    in_write;
   logic [P_DATAMODE_W-1:0] in_datamode;
   logic [P_CTRLMODE_W-1:0] in_ctrlmode;
   logic [AW-1:0]           in_dstaddr;
   logic [AW-1:0]           in_srcaddr;
   logic [DW-1:0]           in_data;
   logic [IW-1:0]           idx;

   logic [3:0]              lane_en;                // Byte lanes to write
   logic [DW-1:0]           wr_data;                // Data replicated onto lanes
   logic [DW-1:0]           rd_data;
   logic [PW-1:0]           resp_packet;

   logic                    accept;
   logic                    wr_en;
   logic                    rd_en;
   logic                    drain;

   logic [DW-1:0]           mem [MEM_DEPTH];        // Word array

   //##########################################################
   //# Field decode
   //##########################################################
   assign in_write    = packet_in[P_WRITE_LO];
   assign in_datamode = packet_in[P_DATAMODE_LO +: P_DATAMODE_W];
   assign in_ctrlmode = packet_in[P_CTRLMODE_LO +: P_CTRLMODE_W];
   assign in_dstaddr  = packet_in[P_DSTADDR_LO +: P_DSTADDR_W];
   assign in_srcaddr  = packet_in[P_SRCADDR_LO +: P_SRCADDR_W];
   assign in_data     = packet_in[P_DATA_LO +: P_DATA_W];
   assign idx         = in_dstaddr[WORD_LSB +: IW];

   //##########################################################
   //# Handshake
   //##########################################################
   assign drain    = access_out & ~wait_in;         // Response leaves this cycle
   assign wait_out = access_out &  wait_in;         // Writes held too, keeps order
   assign accept   = access_in & ~wait_out;
   assign wr_en    = accept &  in_write;
   assign rd_en    = accept & ~in_write;            // Register empty or draining

   //##########################################################
   //# Write lanes
   //##########################################################
   always_comb begin
      case (in_datamode)
         DM_BYTE: begin
            lane_en = 4'b0001 << in_dstaddr[1:0];   // One lane by addr[1:0]
            wr_data = {4{in_data[7:0]}};
         end
         DM_HALF: begin
            lane_en = in_dstaddr[1] ? 4'b1100 : 4'b0011;
            wr_data = {2{in_data[15:0]}};
         end
         default: begin
            lane_en = 4'b1111;                      // Word and double
            wr_data = in_data;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (wr_en && lane_en[i]) begin
            mem[idx][8*i +: 8] <= wr_data[8*i +: 8];
         end
      end
   end

   //##########################################################
   //# Read response
   //##########################################################
   assign rd_data = mem[idx];                       // Always the full word

   always_comb begin
      resp_packet                                = '0;
      resp_packet[P_WRITE_LO]                    = 1'b1;
      resp_packet[P_DATAMODE_LO +: P_DATAMODE_W] = in_datamode;
      resp_packet[P_CTRLMODE_LO +: P_CTRLMODE_W] = in_ctrlmode;
      resp_packet[P_DSTADDR_LO +: P_DSTADDR_W]   = in_srcaddr;  // Back to requester
      resp_packet[P_DATA_LO +: P_DATA_W]         = rd_data;
      resp_packet[P_SRCADDR_LO +: P_SRCADDR_W]   = in_dstaddr;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         access_out <= 1'b0;
      end else if (rd_en) begin
         access_out <= 1'b1;
      end else if (drain) begin
         access_out <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         packet_out <= resp_packet;                 // Holds under wait_in
      end
   end

endmodule

//--- hw/emesh_rr_merge.sv
`timescale 1ns/1ps

module emesh_rr_merge (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [1:0]               rr_access,
   input  logic [emesh_pkg::PW-1:0] rr_packet0,
   input  logic [emesh_pkg::PW-1:0] rr_packet1,
   input  logic                     wait_in,
   output logic [1:0]               rr_wait,
   output logic                     access_out,
   output logic [emesh_pkg::PW-1:0] packet_out
);
   import emesh_pkg::*;

   logic       ptr;                                 // Preferred bank
   logic [1:0] gnt;                                 // One-hot grant
   logic       load_ok;                             // Output register free or draining
   logic       load;
   logic       winner;

   //##########################################################
   //# Arbitration
   //##########################################################
   always_comb begin
      gnt = 2'b00;
      if (rr_access == 2'b11) begin
         gnt[ptr] = 1'b1;                           // Both ask, pointer decides
      end else begin
         gnt = rr_access;                           // Zero or one request
      end
   end

   assign winner  = gnt[1];
   assign load_ok = ~access_out | ~wait_in;
   assign load    = load_ok & (|gnt);

   // Stall on a full register, or lose to the other bank
   assign rr_wait[0] = ~load_ok | (rr_access[1] & ~gnt[0]);
   assign rr_wait[1] = ~load_ok | (rr_access[0] & ~gnt[1]);

   //##########################################################
   //# Output register and pointer
   //##########################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         access_out <= 1'b0;
         ptr        <= 1'b0;                        // Bank 0 first
      end else if (load) begin
         access_out <= 1'b1;
         ptr        <= ~winner;                     // Move past the winner
      end else if (~wait_in) begin
         access_out <= 1'b0;                        // Drained, nothing new
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         packet_out <= winner ? rr_packet1 : rr_packet0;
      end
   end

endmodule

//--- hw/emesh_mem_top.sv
`timescale 1ns/1ps

module emesh_mem_top #(
   parameter int BANK_BIT  = emesh_pkg::BANK_BIT_DEFAULT,
   parameter int MEM_DEPTH = emesh_pkg::MEM_DEPTH_DEFAULT
) (
   input  logic                     clk,
   input  logic                     reset,
   // Request side
   input  logic                     access_in,
   input  logic [emesh_pkg::PW-1:0] packet_in,
   output logic                     wait_out,
   // Response side
   output logic                     access_out,
   output logic [emesh_pkg::PW-1:0] packet_out,
   input  logic                     wait_in
);
   import emesh_pkg::*;

   // Router to banks
   logic [1:0]    bank_access;
   logic [PW-1:0] bank_packet;                      // Shared, one access at a time
   logic [1:0]    bank_wait;

   // Banks to merge
   logic [1:0]    rr_access;
   logic [PW-1:0] rr_packet0;
   logic [PW-1:0] rr_packet1;
   logic [1:0]    rr_wait;

   //##########################################################
   //# Request steering
   //##########################################################
   emesh_bank_router #(.BANK_BIT(BANK_BIT)) u_router (
      .clk         (clk),
      .reset       (reset),
      .access_in   (access_in),
      .packet_in   (packet_in),
      .bank_wait   (bank_wait),
      .wait_out    (wait_out),
      .bank_access (bank_access),
      .bank_packet (bank_packet)
   );

   //##########################################################
   //# Memory banks
   //##########################################################
   ememory #(.MEM_DEPTH(MEM_DEPTH)) u_bank0 (
      .clk        (clk),
      .reset      (reset),
      .access_in  (bank_access[0]),
      .packet_in  (bank_packet),
      .wait_in    (rr_wait[0]),                     // Merge pushback
      .wait_out   (bank_wait[0]),
      .access_out (rr_access[0]),
      .packet_out (rr_packet0)
   );

   ememory #(.MEM_DEPTH(MEM_DEPTH)) u_bank1 (
      .clk        (clk),
      .reset      (reset),
      .access_in  (bank_access[1]),
      .packet_in  (bank_packet),
      .wait_in    (rr_wait[1]),
      .wait_out   (bank_wait[1]),
      .access_out (rr_access[1]),
      .packet_out (rr_packet1)
   );

   //##########################################################
   //# Response merge
   //##########################################################
   emesh_rr_merge u_merge (
      .clk        (clk),
      .reset      (reset),
      .rr_access  (rr_access),
      .rr_packet0 (rr_packet0),
      .rr_packet1 (rr_packet1),
      .wait_in    (wait_in),
      .rr_wait    (rr_wait),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

//--- testbench/tb_emesh_mem.sv
`timescale 1ns/1ps

module tb_emesh_mem;
   import emesh_pkg::*;

   localparam int          N_RANDOM = 300;          // Random transactions
   localparam int          N_FILL   = 16;           // Prefilled words per bank
   localparam logic [31:0] TAG_BASE = 32'hC000_0000; // Srcaddr tags count up from here

   logic          clk = 1'b0;
   logic          reset;
   logic          access_in;
   logic [PW-1:0] packet_in;
   logic          wait_out;
   logic          access_out;
   logic [PW-1:0] packet_out;
   logic          wait_in = 1'b0;

   logic          wait_random = 1'b0;               // Random back-pressure enable
   logic [15:0]   lfsr = 16'd62;                    // Stimulus LFSR
   logic [15:0]   wait_lfsr = 16'd62;               // Back-pressure LFSR
   int            cycle = 0;
   int            issued = 0;                       // Accepted requests
   int            tag_count = 0;
   logic [31:0]   latency_tag = 32'hFFFF_FFFF;      // Read whose latency is checked

   logic [DW-1:0] model [2][256];                   // Reference banks
   logic [PW-1:0] exp_tab [logic [31:0]];           // Expected responses by tag
   int            acc_cyc [logic [31:0]];           // Acceptance cycle by tag
   logic [31:0]   order_q0 [$];                     // Outstanding read tags, bank 0
   logic [31:0]   order_q1 [$];                     // Same for bank 1

   emesh_mem_top u_dut (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   always #20 clk = ~clk;                           // 40 ns period

   //##########################################################
   //# Random bits and reference model
   //##########################################################
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);                    // One step per bit
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] bank_addr(input logic bank, input logic [7:0] idx,
                                             input logic [1:0] off);
      return {21'd0, bank, idx, off};               // Bank on bit 10
   endfunction

   function automatic logic [DW-1:0] merge_write(input logic [DW-1:0] old,
                                                 input logic [PW-1:0] req);
      logic [1:0]    dm;
      logic [1:0]    off;
      logic [DW-1:0] data;
      logic [DW-1:0] word;
      dm   = req[P_DATAMODE_LO +: P_DATAMODE_W];
      off  = req[P_DSTADDR_LO +: 2];
      data = req[P_DATA_LO +: P_DATA_W];
      word = old;
      if (dm == DM_BYTE) begin
         word[8*off +: 8] = data[7:0];              // Lane by addr[1:0]
      end else if (dm == DM_HALF) begin
         word[16*off[1] +: 16] = data[15:0];        // Half by addr[1]
      end else begin
         word = data;                               // Word and double
      end
      return word;
   endfunction

   // Swapped addresses and the full word, with the write flag set
   function automatic logic [PW-1:0] expected_response(input logic [PW-1:0] req,
                                                       input logic [DW-1:0] word);
      return {req[P_DSTADDR_LO +: AW], word, req[P_SRCADDR_LO +: AW],
              req[P_CTRLMODE_LO +: P_CTRLMODE_W], req[P_DATAMODE_LO +: P_DATAMODE_W], 1'b1};
   endfunction

   //##########################################################
   //# Checks and scoreboard
   //##########################################################
   task automatic check_value(input logic [PW-1:0] got, input logic [PW-1:0] want,
                              input string what);
      if (got !== want) begin
         $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, want);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic record_request(input logic [PW-1:0] req);
      logic        bank;
      logic [7:0]  idx;
      logic [31:0] tag;
      bank = req[P_DSTADDR_LO + BANK_BIT_DEFAULT];
      idx  = req[P_DSTADDR_LO + WORD_LSB +: 8];
      tag  = req[P_SRCADDR_LO +: P_SRCADDR_W];
      issued++;
      if (req[P_WRITE_LO]) begin
         model[bank][idx] = merge_write(model[bank][idx], req);
      end else begin
         exp_tab[tag] = expected_response(req, model[bank][idx]); // Model at acceptance
         acc_cyc[tag] = cycle;
         if (bank) begin
            order_q1.push_back(tag);
         end else begin
            order_q0.push_back(tag);
         end
      end
   endtask

   task automatic check_response(input logic [PW-1:0] rsp);
      logic [31:0]   tag;
      logic [31:0]   head;
      logic [PW-1:0] exp_pkt;
      tag = rsp[P_DSTADDR_LO +: P_DSTADDR_W];       // Tag returns as dstaddr
      if (!exp_tab.exists(tag)) begin
         $display("Response at %0t carries tag %h that matches no outstanding read",
                  $time, tag);
         $display("TEST FAILED");
         $fatal(1, "stray response");
      end
      exp_pkt = exp_tab[tag];
      if (exp_pkt[P_SRCADDR_LO + BANK_BIT_DEFAULT]) begin
         head = order_q1.pop_front();
      end else begin
         head = order_q0.pop_front();
      end
      check_value(PW'(tag), PW'(head), "response order within bank");
      check_value(rsp, exp_pkt, "response packet");
      if (tag == latency_tag) begin
         check_value(PW'(cycle - acc_cyc[tag]), PW'(3), "idle read latency");
      end
      exp_tab.delete(tag);
      acc_cyc.delete(tag);
   endtask

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (!reset) begin
         if (access_in && !wait_out) begin
            record_request(packet_in);
         end
         if (access_out && !wait_in) begin
            check_response(packet_out);
         end
         if (cycle > 20 * issued + 200) begin
            $display("Timeout after %0d cycles, %0d responses went missing",
                     cycle, exp_tab.num());
            $display("TEST FAILED");
            $fatal(1, "timeout");
         end
      end
   end

   always @(negedge clk) begin
      if (wait_random) begin
         wait_lfsr = lfsr_step(wait_lfsr);
         wait_in   = wait_lfsr[0];                  // About half the cycles stalled
      end else begin
         wait_in = 1'b0;
      end
   end

   //##########################################################
   //# Stimulus
   //##########################################################
   task automatic send_packet(input logic wr, input logic [1:0] dm, input logic [4:0] ctrl,
                              input logic [31:0] dst, input logic [31:0] data);
      @(negedge clk);
      access_in = 1'b1;
      packet_in = {TAG_BASE + 32'(tag_count), data, dst, ctrl, dm, wr};
      tag_count++;
      do begin
         @(posedge clk);
      end while (wait_out);                         // Held until accepted
   endtask

   task automatic drain_responses();
      @(negedge clk);
      access_in = 1'b0;
      while (exp_tab.num() != 0) begin
         @(negedge clk);
      end
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] r;
      reset     = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      for (int c = 0; c < 7; c++) begin
         @(negedge clk);
         check_value(PW'(access_out), PW'(0), "access_out around reset");
         check_value(PW'(wait_out), PW'(0), "wait_out around reset");
         if (c == 4) begin
            reset = 1'b0;                           // Five cycles high
         end
      end
      for (int b = 0; b < 2; b++) begin
         for (int i = 0; i < N_FILL; i++) begin
            a = bank_addr(b[0], 8'(i), 2'd0);
            send_packet(1'b1, DM_WORD, 5'd0, a, a ^ {a[15:0], a[31:16]} ^ 32'h3C5A_96E1);
         end
      end
      // Word write and read back
      send_packet(1'b1, DM_WORD, 5'h0A, bank_addr(1'b0, 8'd3, 2'd0), 32'hDEAD_BEEF);
      send_packet(1'b0, DM_WORD, 5'h15, bank_addr(1'b0, 8'd3, 2'd0), 32'd0);
      // Byte and halfword lanes
      send_packet(1'b1, DM_WORD, 5'h00, bank_addr(1'b0, 8'd5, 2'd0), 32'h1122_3344);
      send_packet(1'b1, DM_BYTE, 5'h00, bank_addr(1'b0, 8'd5, 2'd2), 32'hFFFF_FFAB);
      send_packet(1'b1, DM_HALF, 5'h00, bank_addr(1'b0, 8'd5, 2'd0), 32'hFFFF_BEEF);
      send_packet(1'b0, DM_WORD, 5'h03, bank_addr(1'b0, 8'd5, 2'd0), 32'd0);
      send_packet(1'b1, DM_BYTE, 5'h00, bank_addr(1'b1, 8'd5, 2'd1), 32'hFFFF_FF5A);
      send_packet(1'b1, DM_HALF, 5'h00, bank_addr(1'b1, 8'd5, 2'd2), 32'h1234_C0DE);
      send_packet(1'b0, DM_BYTE, 5'h1F, bank_addr(1'b1, 8'd5, 2'd1), 32'd0);
      // Same index, other bank
      send_packet(1'b1, DM_WORD, 5'h00, bank_addr(1'b1, 8'd3, 2'd0), 32'h0BAD_F00D);
      send_packet(1'b0, DM_WORD, 5'h06, bank_addr(1'b0, 8'd3, 2'd0), 32'd0);
      send_packet(1'b0, DM_WORD, 5'h07, bank_addr(1'b1, 8'd3, 2'd0), 32'd0);
      drain_responses();
      latency_tag = TAG_BASE + 32'(tag_count);      // Lone read, idle output
      send_packet(1'b0, DM_WORD, 5'h01, bank_addr(1'b1, 8'd3, 2'd0), 32'd0);
      drain_responses();
      @(posedge clk);
      wait_random = 1'b1;
      for (int n = 0; n < N_RANDOM; n++) begin
         r = rand_bits(15);                         // bank, idx, off, dm, wr, ctrl
         send_packet(r[5], r[7:6], r[4:0],
                     bank_addr(r[14], {4'd0, r[13:10]}, r[9:8]), rand_bits(32));
         if (rand_bits(2) == 32'd0) begin
            @(negedge clk);
            access_in = 1'b0;                       // Occasional idle cycle
         end
      end
      drain_responses();
      $display("TEST OK");
      $finish;
   end

endmodule

//--- vlog.f
hw/emesh_pkg.sv
hw/emesh_bank_router.sv
hw/ememory.sv
hw/emesh_rr_merge.sv
hw/emesh_mem_top.sv
testbench/tb_emesh_mem.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing
TOP         = tb_emesh_mem
RTL_TOP     = emesh_mem_top
FILELIST    = vlog.f
OBJ_DIR     = obj_dir
LOG         = sim.log
PASS_MSG    = TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
